/* ex_pkg.sv */
package ex_pkg;

    // Default datapath and address widths
    localparam int DATA_W  = 24;
    localparam int PC_W    = 48;

    // Instruction immediate fields
    localparam int IMM12_W = 12;
    localparam int IMM16_W = 16;

    // Flag word layout
    localparam int FLAG_W  = 4;

    typedef enum int unsigned {
        FLAG_Z = 0,
        FLAG_N = 1,
        FLAG_C = 2,
        FLAG_V = 3
    } flag_idx_e;

    // Opcodes handled by the execute stage
    typedef enum logic [7:0] {
        OPC_MOVur = 8'h01,
        OPC_ADDur = 8'h02,
        OPC_SUBur = 8'h03,
        OPC_ANDur = 8'h04,
        OPC_ORur  = 8'h05,
        OPC_XORur = 8'h06,
        OPC_NOTur = 8'h07,
        OPC_SHLur = 8'h08,
        OPC_SHRur = 8'h09,
        OPC_ROLur = 8'h0A,
        OPC_RORur = 8'h0B,
        OPC_CMPur = 8'h0C,
        OPC_TSTur = 8'h0D,
        OPC_MCCur = 8'h0E,
        OPC_ADDsr = 8'h20,
        OPC_SUBsr = 8'h21,
        OPC_CMPsr = 8'h22,
        OPC_LUIui = 8'h30,
        OPC_MOVui = 8'h31,
        OPC_ADDui = 8'h32,
        OPC_SUBui = 8'h33,
        OPC_ANDui = 8'h34,
        OPC_ORui  = 8'h35,
        OPC_XORui = 8'h36,
        OPC_MOVsi = 8'h40,
        OPC_BCCso = 8'h50,
        OPC_BALso = 8'h51
    } opcode_e;

    // Condition codes
    typedef enum logic [3:0] {
        CC_RA = 4'd0,
        CC_EQ = 4'd1,
        CC_NE = 4'd2,
        CC_LT = 4'd3,
        CC_GT = 4'd4,
        CC_GE = 4'd5,
        CC_LE = 4'd6,
        CC_BT = 4'd7,
        CC_AT = 4'd8,
        CC_BE = 4'd9,
        CC_AE = 4'd10
    } cc_e;

endpackage

/* ex_shift_unit.sv */
`timescale 1ns/1ps

module ex_shift_unit #(
    parameter int DATA_W = ex_pkg::DATA_W,
    parameter int PC_W   = ex_pkg::PC_W
) (
    input  ex_pkg::opcode_e   opc,
    input  logic [DATA_W-1:0] value,
    input  logic [DATA_W-1:0] amount,
    output logic [DATA_W-1:0] sh_result,
    output logic              sh_carry,
    output logic              sh_flags_we
);
    import ex_pkg::*;

    localparam int SH_W = $clog2(DATA_W);

    logic                over;
    logic [SH_W-1:0]     sh_n;
    logic [SH_W-1:0]     rot_n;
    logic [DATA_W:0]     shl_ext;
    logic [DATA_W:0]     shr_ext;
    logic [2*DATA_W-1:0] rol_ext;
    logic [2*DATA_W-1:0] ror_ext;

    if (PC_W < DATA_W || DATA_W <= IMM12_W) begin : g_cfg_err
        $error("ex_shift_unit: unsupported DATA_W and PC_W combination");
    end

    assign over  = amount >= DATA_W;
    assign sh_n  = amount[SH_W-1:0];
    assign rot_n = SH_W'(amount % DATA_W);

    // The extra bit holds the last bit shifted out
    assign shl_ext = {1'b0, value} << sh_n;
    assign shr_ext = {value, 1'b0} >> sh_n;

    // Rotates taken from a doubled copy of the value
    assign rol_ext = {value, value} << rot_n;
    assign ror_ext = {value, value} >> rot_n;

    always_comb begin
        sh_result   = value;
        sh_carry    = 1'b0;
        sh_flags_we = 1'b0;
        case (opc)
            OPC_SHLur: begin
                sh_result   = over ? '0 : shl_ext[DATA_W-1:0];
                sh_carry    = over ? 1'b0 : shl_ext[DATA_W];
                sh_flags_we = amount != '0;
            end
            OPC_SHRur: begin
                sh_result   = over ? '0 : shr_ext[DATA_W:1];
                sh_carry    = over ? 1'b0 : shr_ext[0];
                sh_flags_we = amount != '0;
            end
            OPC_ROLur: begin
                // Bit that wrapped last lands in bit 0
                sh_result   = rol_ext[2*DATA_W-1:DATA_W];
                sh_carry    = rol_ext[DATA_W];
                sh_flags_we = amount != '0;
            end
            OPC_RORur: begin
                sh_result   = ror_ext[DATA_W-1:0];
                sh_carry    = ror_ext[DATA_W-1];
                sh_flags_we = amount != '0;
            end
            default: begin
            end
        endcase
    end

endmodule

/* ex_cond_eval.sv */
`timescale 1ns/1ps

module ex_cond_eval #(
    parameter int DATA_W = ex_pkg::DATA_W,
    parameter int PC_W   = ex_pkg::PC_W
) (
    input  ex_pkg::cc_e               cc,
    input  logic [ex_pkg::FLAG_W-1:0] flags,
    output logic                      cc_true
);
    import ex_pkg::*;

    logic lt;

    if (PC_W < DATA_W || DATA_W <= IMM12_W) begin : g_cfg_err
        $error("ex_cond_eval: unsupported DATA_W and PC_W combination");
    end

    // Signed less-than
    assign lt = flags[FLAG_N] ^ flags[FLAG_V];

    always_comb begin
        case (cc)
            CC_RA:   cc_true = 1'b1;
            CC_EQ:   cc_true = flags[FLAG_Z];
            CC_NE:   cc_true = !flags[FLAG_Z];
            CC_LT:   cc_true = lt;
            CC_GT:   cc_true = !flags[FLAG_Z] && !lt;
            CC_GE:   cc_true = !lt;
            CC_LE:   cc_true = flags[FLAG_Z] || lt;
            CC_BT:   cc_true = flags[FLAG_C];
            CC_AT:   cc_true = !flags[FLAG_C] && !flags[FLAG_Z];
            CC_BE:   cc_true = flags[FLAG_C] || flags[FLAG_Z];
            CC_AE:   cc_true = !flags[FLAG_C];
            default: cc_true = 1'b0;
        endcase
    end

endmodule

/* ex_operand_stage.sv */
`timescale 1ns/1ps

module ex_operand_stage #(
    parameter int DATA_W = ex_pkg::DATA_W,
    parameter int PC_W   = ex_pkg::PC_W
) (
    input  logic                       iw_clk,
    input  logic                       iw_rst,
    input  logic                       stall,
    input  logic                       flush,
    input  logic                       in_valid,
    input  ex_pkg::opcode_e            opc,
    input  ex_pkg::cc_e                cc,
    input  logic [PC_W-1:0]            pc,
    input  logic [3:0]                 tgt,
    input  logic [DATA_W-1:0]          src_val,
    input  logic [DATA_W-1:0]          tgt_val,
    input  logic [ex_pkg::IMM12_W-1:0] imm12,
    input  logic [ex_pkg::IMM16_W-1:0] imm16,
    input  logic [ex_pkg::FLAG_W-1:0]  flags,
    output logic                       op_valid,
    output ex_pkg::opcode_e            op_opc,
    output ex_pkg::cc_e                op_cc,
    output logic [DATA_W-1:0]          op_a,
    output logic [DATA_W-1:0]          op_b,
    output logic [ex_pkg::FLAG_W-1:0]  op_flags,
    output logic [PC_W-1:0]            op_pc,
    output logic [3:0]                 op_tgt,
    output logic [PC_W-1:0]            op_imm_branch
);
    import ex_pkg::*;

    localparam int UIMM_W = 2 * IMM12_W;

    logic [IMM12_W-1:0] uimm_bank;
    logic [UIMM_W-1:0]  uimm_full;
    logic [DATA_W-1:0]  b_sel;
    logic [PC_W-1:0]    br_off;

    // Upper half of the unsigned immediate, loaded by LUI
    always_ff @(posedge iw_clk or posedge iw_rst) begin
        if (iw_rst) begin
            uimm_bank <= '0;
        end else if (!stall) begin
            if (flush) begin
                uimm_bank <= '0;
            end else if (in_valid && opc == OPC_LUIui) begin
                uimm_bank <= imm12;
            end
        end
    end

    assign uimm_full = {uimm_bank, imm12};

    always_comb begin
        case (opc)
            OPC_MOVui, OPC_ADDui, OPC_SUBui, OPC_ANDui, OPC_ORui, OPC_XORui: begin
                b_sel = DATA_W'(uimm_full);
            end
            OPC_MOVsi: begin
                b_sel = DATA_W'(signed'(imm12));
            end
            default: begin
                b_sel = src_val;
            end
        endcase
    end

    // BAL carries the long offset, BCC the short one
    assign br_off = (opc == OPC_BALso) ? PC_W'(signed'(imm16)) : PC_W'(signed'(imm12));

    always_ff @(posedge iw_clk or posedge iw_rst) begin
        if (iw_rst) begin
            op_valid <= 1'b0;
        end else if (!stall) begin
            op_valid <= in_valid && !flush;
        end
    end

    always_ff @(posedge iw_clk) begin
        if (!stall) begin
            op_opc        <= opc;
            op_cc         <= cc;
            op_a          <= tgt_val;
            op_b          <= b_sel;
            op_flags      <= flags;
            op_pc         <= pc;
            op_tgt        <= tgt;
            op_imm_branch <= br_off;
        end
    end

endmodule

/* ex_compute_stage.sv */
`timescale 1ns/1ps

module ex_compute_stage #(
    parameter int DATA_W = ex_pkg::DATA_W,
    parameter int PC_W   = ex_pkg::PC_W
) (
    input  logic                      iw_clk,
    input  logic                      iw_rst,
    input  logic                      stall,
    input  logic                      flush,
    input  logic                      op_valid,
    input  ex_pkg::opcode_e           op_opc,
    input  ex_pkg::cc_e               op_cc,
    input  logic [DATA_W-1:0]         op_a,
    input  logic [DATA_W-1:0]         op_b,
    input  logic [ex_pkg::FLAG_W-1:0] op_flags,
    input  logic [PC_W-1:0]           op_pc,
    input  logic [3:0]                op_tgt,
    input  logic [PC_W-1:0]           op_imm_branch,
    output logic                      out_valid,
    output logic [DATA_W-1:0]         result,
    output logic [3:0]                gp_tgt,
    output logic                      gp_we,
    output logic [ex_pkg::FLAG_W-1:0] flags_out,
    output logic                      flags_we,
    output logic                      branch_taken,
    output logic [PC_W-1:0]           branch_pc
);
    import ex_pkg::*;

    logic [DATA_W:0]   sum;
    logic [DATA_W:0]   diff;
    logic              add_v;
    logic              sub_v;
    logic [DATA_W-1:0] sh_result;
    logic              sh_carry;
    logic              sh_flags_we;
    logic              cc_true;
    logic [DATA_W-1:0] res_d;
    logic [FLAG_W-1:0] fl_d;
    logic              fl_we_d;
    logic              gp_we_d;
    logic              br_d;
    logic [PC_W-1:0]   br_target;

    ex_shift_unit #(.DATA_W(DATA_W), .PC_W(PC_W)) u_shift (
        .opc        (op_opc),
        .value      (op_a),
        .amount     (op_b),
        .sh_result  (sh_result),
        .sh_carry   (sh_carry),
        .sh_flags_we(sh_flags_we)
    );

    ex_cond_eval #(.DATA_W(DATA_W), .PC_W(PC_W)) u_cond (
        .cc     (op_cc),
        .flags  (op_flags),
        .cc_true(cc_true)
    );

    // Top bit of each is the unsigned carry or borrow
    assign sum  = {1'b0, op_a} + {1'b0, op_b};
    assign diff = {1'b0, op_a} - {1'b0, op_b};
    assign add_v = (op_a[DATA_W-1] == op_b[DATA_W-1]) && (sum[DATA_W-1] != op_a[DATA_W-1]);
    assign sub_v = (op_a[DATA_W-1] != op_b[DATA_W-1]) && (diff[DATA_W-1] != op_a[DATA_W-1]);
    assign br_target = op_pc + op_imm_branch;

    always_comb begin
        res_d   = '0;
        fl_d    = '0;
        fl_we_d = 1'b0;
        gp_we_d = 1'b0;
        br_d    = 1'b0;
        case (op_opc)
            OPC_MOVur, OPC_MOVui, OPC_MOVsi: begin
                res_d   = op_b;
                fl_we_d = 1'b1;
                gp_we_d = 1'b1;
            end
            OPC_ADDur, OPC_ADDui: begin
                res_d         = sum[DATA_W-1:0];
                fl_d[FLAG_C]  = sum[DATA_W];
                fl_we_d       = 1'b1;
                gp_we_d       = 1'b1;
            end
            OPC_SUBur, OPC_SUBui: begin
                res_d         = diff[DATA_W-1:0];
                fl_d[FLAG_C]  = diff[DATA_W];
                fl_we_d       = 1'b1;
                gp_we_d       = 1'b1;
            end
            OPC_ADDsr: begin
                res_d         = sum[DATA_W-1:0];
                fl_d[FLAG_N]  = sum[DATA_W-1];
                fl_d[FLAG_V]  = add_v;
                fl_we_d       = 1'b1;
                gp_we_d       = 1'b1;
            end
            OPC_SUBsr: begin
                res_d         = diff[DATA_W-1:0];
                fl_d[FLAG_N]  = diff[DATA_W-1];
                fl_d[FLAG_V]  = sub_v;
                fl_we_d       = 1'b1;
                gp_we_d       = 1'b1;
            end
            OPC_ANDur, OPC_ANDui, OPC_ORur, OPC_ORui, OPC_XORur, OPC_XORui, OPC_NOTur: begin
                if (op_opc == OPC_ANDur || op_opc == OPC_ANDui) begin
                    res_d = op_a & op_b;
                end else if (op_opc == OPC_ORur || op_opc == OPC_ORui) begin
                    res_d = op_a | op_b;
                end else if (op_opc == OPC_NOTur) begin
                    res_d = ~op_a;
                end else begin
                    res_d = op_a ^ op_b;
                end
                fl_we_d = 1'b1;
                gp_we_d = 1'b1;
            end
            OPC_SHLur, OPC_SHRur, OPC_ROLur, OPC_RORur: begin
                res_d         = sh_result;
                fl_d[FLAG_C]  = sh_carry;
                fl_we_d       = sh_flags_we;
                gp_we_d       = 1'b1;
            end
            OPC_CMPur: begin
                fl_d[FLAG_C]  = diff[DATA_W];
                fl_we_d       = 1'b1;
            end
            OPC_CMPsr: begin
                fl_d[FLAG_N]  = diff[DATA_W-1];
                fl_d[FLAG_V]  = sub_v;
                fl_we_d       = 1'b1;
            end
            OPC_TSTur: begin
                fl_we_d = 1'b1;
            end
            OPC_MCCur: begin
                // A failed condition writes the target back unchanged
                res_d   = cc_true ? op_b : op_a;
                fl_we_d = cc_true;
                gp_we_d = 1'b1;
            end
            OPC_BCCso: br_d = cc_true;
            OPC_BALso: br_d = 1'b1;
            default: begin
            end
        endcase

        if (op_opc == OPC_CMPur || op_opc == OPC_CMPsr) begin
            fl_d[FLAG_Z] = diff[DATA_W-1:0] == '0;
        end else if (op_opc == OPC_TSTur) begin
            fl_d[FLAG_Z] = op_a == '0;
        end else begin
            fl_d[FLAG_Z] = res_d == '0;
        end

        if (!fl_we_d) begin
            fl_d = '0;
        end
    end

    always_ff @(posedge iw_clk or posedge iw_rst) begin
        if (iw_rst) begin
            out_valid    <= 1'b0;
            gp_we        <= 1'b0;
            flags_we     <= 1'b0;
            branch_taken <= 1'b0;
        end else if (!stall) begin
            out_valid    <= op_valid && !flush;
            gp_we        <= op_valid && !flush && gp_we_d;
            flags_we     <= op_valid && !flush && fl_we_d;
            branch_taken <= op_valid && !flush && br_d;
        end
    end

    always_ff @(posedge iw_clk) begin
        if (!stall) begin
            result    <= res_d;
            gp_tgt    <= op_tgt;
            flags_out <= fl_d;
            branch_pc <= br_d ? br_target : '0;
        end
    end

    // Nothing leaves the stage without a valid instruction
    a_idle_quiet: assert property (@(posedge iw_clk) disable iff (iw_rst)
        !out_valid |-> !(gp_we || flags_we || branch_taken));

    a_branch_no_write: assert property (@(posedge iw_clk) disable iff (iw_rst)
        branch_taken |-> !gp_we);

endmodule

/* ex_top.sv */
`timescale 1ns/1ps

module ex_top #(
    parameter int DATA_W = ex_pkg::DATA_W,
    parameter int PC_W   = ex_pkg::PC_W
) (
    input  logic                       iw_clk,
    input  logic                       iw_rst,
    input  logic                       stall,
    input  logic                       flush,
    input  logic                       in_valid,
    input  ex_pkg::opcode_e            opc,
    input  ex_pkg::cc_e                cc,
    input  logic [PC_W-1:0]            pc,
    input  logic [3:0]                 tgt,
    input  logic [DATA_W-1:0]          src_val,
    input  logic [DATA_W-1:0]          tgt_val,
    input  logic [ex_pkg::IMM12_W-1:0] imm12,
    input  logic [ex_pkg::IMM16_W-1:0] imm16,
    input  logic [ex_pkg::FLAG_W-1:0]  flags,
    output logic                       out_valid,
    output logic [DATA_W-1:0]          result,
    output logic [3:0]                 gp_tgt,
    output logic                       gp_we,
    output logic [ex_pkg::FLAG_W-1:0]  flags_out,
    output logic                       flags_we,
    output logic                       branch_taken,
    output logic [PC_W-1:0]            branch_pc
);
    import ex_pkg::*;

    logic              op_valid;
    opcode_e           op_opc;
    cc_e               op_cc;
    logic [DATA_W-1:0] op_a;
    logic [DATA_W-1:0] op_b;
    logic [FLAG_W-1:0] op_flags;
    logic [PC_W-1:0]   op_pc;
    logic [3:0]        op_tgt;
    logic [PC_W-1:0]   op_imm_branch;

    ex_operand_stage #(.DATA_W(DATA_W), .PC_W(PC_W)) u_operand (
        .iw_clk       (iw_clk),
        .iw_rst       (iw_rst),
        .stall        (stall),
        .flush        (flush),
        .in_valid     (in_valid),
        .opc          (opc),
        .cc           (cc),
        .pc           (pc),
        .tgt          (tgt),
        .src_val      (src_val),
        .tgt_val      (tgt_val),
        .imm12        (imm12),
        .imm16        (imm16),
        .flags        (flags),
        .op_valid     (op_valid),
        .op_opc       (op_opc),
        .op_cc        (op_cc),
        .op_a         (op_a),
        .op_b         (op_b),
        .op_flags     (op_flags),
        .op_pc        (op_pc),
        .op_tgt       (op_tgt),
        .op_imm_branch(op_imm_branch)
    );

    ex_compute_stage #(.DATA_W(DATA_W), .PC_W(PC_W)) u_compute (
        .iw_clk       (iw_clk),
        .iw_rst       (iw_rst),
        .stall        (stall),
        .flush        (flush),
        .op_valid     (op_valid),
        .op_opc       (op_opc),
        .op_cc        (op_cc),
        .op_a         (op_a),
        .op_b         (op_b),
        .op_flags     (op_flags),
        .op_pc        (op_pc),
        .op_tgt       (op_tgt),
        .op_imm_branch(op_imm_branch),
        .out_valid    (out_valid),
        .result       (result),
        .gp_tgt       (gp_tgt),
        .gp_we        (gp_we),
        .flags_out    (flags_out),
        .flags_we     (flags_we),
        .branch_taken (branch_taken),
        .branch_pc    (branch_pc)
    );

endmodule

/* tb_clock_gen.sv */
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter int PERIOD_NS  = 10,
    parameter int RST_CYCLES = 16
) (
    output logic iw_clk,
    output logic iw_rst
);
    initial begin
        iw_clk = 1'b0;
        forever #(PERIOD_NS / 2) iw_clk = ~iw_clk;
    end

    // Reset drops on a falling edge, clear of the sampling edge
    initial begin
        iw_rst = 1'b1;
        repeat (RST_CYCLES) @(posedge iw_clk);
        @(negedge iw_clk);
        iw_rst = 1'b0;
    end

endmodule

/* tb_ex_top.sv */
`timescale 1ns/1ps

module tb_ex_top;
    import ex_pkg::*;

    localparam int DW = ex_pkg::DATA_W;
    localparam int PW = ex_pkg::PC_W;

    typedef struct packed {
        logic          valid;
        logic          stall;
        logic          flush;
        opcode_e       opc;
        cc_e           cc;
        logic [3:0]    tgt;
        logic [DW-1:0] a;
        logic [DW-1:0] src;
        logic [11:0]   imm12;
        logic [15:0]   imm16;
        logic [3:0]    flags;
        logic [PW-1:0] pc;
    } row_t;

    typedef struct packed {
        logic [DW-1:0] res;
        logic [3:0]    tgt;
        logic          gp_we;
        logic [3:0]    fl;
        logic          fl_we;
        logic          br;
        logic [PW-1:0] bpc;
    } exp_t;

    logic          iw_clk;
    logic          iw_rst;
    logic          stall;
    logic          flush;
    logic          in_valid;
    opcode_e       opc;
    cc_e           cc;
    logic [PW-1:0] pc;
    logic [3:0]    tgt;
    logic [DW-1:0] src_val;
    logic [DW-1:0] tgt_val;
    logic [11:0]   imm12;
    logic [15:0]   imm16;
    logic [3:0]    flags;
    logic          out_valid;
    logic [DW-1:0] result;
    logic [3:0]    gp_tgt;
    logic          gp_we;
    logic [3:0]    flags_out;
    logic          flags_we;
    logic          branch_taken;
    logic [PW-1:0] branch_pc;

    row_t        rows[$];
    exp_t        s1;
    exp_t        s2;
    logic        s1_v;
    logic        s2_v;
    logic [11:0] bank;
    logic [31:0] lcg_state;

    tb_clock_gen #(.PERIOD_NS(10), .RST_CYCLES(16)) u_clk (.iw_clk(iw_clk), .iw_rst(iw_rst));

    ex_top #(.DATA_W(DW), .PC_W(PW)) uut (
        .iw_clk(iw_clk), .iw_rst(iw_rst), .stall(stall), .flush(flush),
        .in_valid(in_valid), .opc(opc), .cc(cc), .pc(pc), .tgt(tgt),
        .src_val(src_val), .tgt_val(tgt_val), .imm12(imm12), .imm16(imm16),
        .flags(flags), .out_valid(out_valid), .result(result), .gp_tgt(gp_tgt),
        .gp_we(gp_we), .flags_out(flags_out), .flags_we(flags_we),
        .branch_taken(branch_taken), .branch_pc(branch_pc)
    );

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    function automatic logic cond_holds(cc_e c, logic [3:0] f);
        logic lt;
        lt = f[FLAG_N] ^ f[FLAG_V];
        case (c)
            CC_RA: return 1'b1;
            CC_EQ: return f[FLAG_Z];
            CC_NE: return !f[FLAG_Z];
            CC_LT: return lt;
            CC_GT: return !f[FLAG_Z] && !lt;
            CC_GE: return !lt;
            CC_LE: return f[FLAG_Z] || lt;
            CC_BT: return f[FLAG_C];
            CC_AT: return !f[FLAG_C] && !f[FLAG_Z];
            CC_BE: return f[FLAG_C] || f[FLAG_Z];
            CC_AE: return !f[FLAG_C];
            default: return 1'b0;
        endcase
    endfunction

    function automatic logic out_of_range(longint v);
        return v > longint'(2 ** (DW - 1) - 1) || v < -longint'(2 ** (DW - 1));
    endfunction

    function automatic exp_t expect_row(row_t r, logic [11:0] bank_now);
        exp_t          e;
        logic [DW-1:0] b;
        logic [63:0]   t;
        longint        sa;
        longint        sb;
        int            amt;
        int            k;
        logic          cond;
        e = '0;
        e.tgt = r.tgt;
        case (r.opc)
            OPC_MOVui, OPC_ADDui, OPC_SUBui, OPC_ANDui, OPC_ORui, OPC_XORui:
                b = DW'({bank_now, r.imm12});
            OPC_MOVsi: b = {{(DW - 12){r.imm12[11]}}, r.imm12};
            default:   b = r.src;
        endcase
        sa = longint'($signed(r.a));
        sb = longint'($signed(b));
        amt = (b >= DW) ? DW : int'(b);
        cond = cond_holds(r.cc, r.flags);
        e.fl_we = 1'b1;
        e.gp_we = 1'b1;
        case (r.opc)
            OPC_MOVur, OPC_MOVui, OPC_MOVsi: e.res = b;
            OPC_ADDur, OPC_ADDui: begin
                e.res = r.a + b;
                e.fl[FLAG_C] = (64'(r.a) + 64'(b)) >= 64'(2 ** DW);
            end
            OPC_SUBur, OPC_SUBui: begin
                e.res = r.a - b;
                e.fl[FLAG_C] = r.a < b;
            end
            OPC_ADDsr, OPC_SUBsr: begin
                e.res = (r.opc == OPC_ADDsr) ? r.a + b : r.a - b;
                e.fl[FLAG_N] = e.res[DW-1];
                e.fl[FLAG_V] = out_of_range((r.opc == OPC_ADDsr) ? sa + sb : sa - sb);
            end
            OPC_ANDur, OPC_ANDui: e.res = r.a & b;
            OPC_ORur, OPC_ORui:   e.res = r.a | b;
            OPC_XORur, OPC_XORui: e.res = r.a ^ b;
            OPC_NOTur:            e.res = ~r.a;
            OPC_SHLur, OPC_SHRur: begin
                e.fl_we = b != '0;
                if (amt < DW && r.opc == OPC_SHLur) begin
                    t = 64'(r.a) << amt;
                    e.res = t[DW-1:0];
                    e.fl[FLAG_C] = (amt != 0) && t[DW];
                end else if (amt < DW) begin
                    e.res = r.a >> amt;
                    e.fl[FLAG_C] = (amt != 0) && r.a[amt - 1];
                end
            end
            OPC_ROLur, OPC_RORur: begin
                e.fl_we = b != '0;
                amt = int'(b % DW);
                // Move each bit to its rotated position
                for (k = 0; k < DW; k++) begin
                    if (r.opc == OPC_ROLur) begin
                        e.res[(k + amt) % DW] = r.a[k];
                    end else begin
                        e.res[k] = r.a[(k + amt) % DW];
                    end
                end
                e.fl[FLAG_C] = (r.opc == OPC_ROLur) ? e.res[0] : e.res[DW-1];
            end
            OPC_CMPur: begin
                e.gp_we = 1'b0;
                e.fl[FLAG_C] = r.a < b;
            end
            OPC_CMPsr: begin
                e.gp_we = 1'b0;
                e.fl[FLAG_N] = sa - sb < 0 ? !out_of_range(sa - sb) : out_of_range(sa - sb);
                e.fl[FLAG_V] = out_of_range(sa - sb);
            end
            OPC_TSTur: e.gp_we = 1'b0;
            OPC_MCCur: begin
                e.res = cond ? b : r.a;
                e.fl_we = cond;
            end
            OPC_BCCso, OPC_BALso: begin
                e.gp_we = 1'b0;
                e.fl_we = 1'b0;
                e.br = (r.opc == OPC_BALso) || cond;
                if (r.opc == OPC_BALso) begin
                    e.bpc = r.pc + {{(PW - 16){r.imm16[15]}}, r.imm16};
                end else begin
                    e.bpc = r.pc + {{(PW - 12){r.imm12[11]}}, r.imm12};
                end
            end
            default: begin
                e.gp_we = 1'b0;
                e.fl_we = 1'b0;
            end
        endcase
        if (r.opc == OPC_CMPur || r.opc == OPC_CMPsr) begin
            e.fl[FLAG_Z] = r.a == b;
        end else if (r.opc == OPC_TSTur) begin
            e.fl[FLAG_Z] = r.a == '0;
        end else begin
            e.fl[FLAG_Z] = e.res == '0;
        end
        if (!e.fl_we) begin
            e.fl = '0;
        end
        return e;
    endfunction

    task automatic compare(string what, logic [63:0] got, logic [63:0] exp);
        if (got !== exp) begin
            $display("MISMATCH at %0t ns: %s is %h, expected %h", $time, what, got, exp);
            $display(">>> FAIL");
            $fatal(1);
        end
    endtask

    task automatic add_row(opcode_e o, cc_e c, logic [DW-1:0] a, logic [DW-1:0] s,
                           logic [11:0] i12, logic [15:0] i16, logic [3:0] f, logic [PW-1:0] p);
        row_t r;
        r = '{valid: 1'b1, stall: 1'b0, flush: 1'b0, opc: o, cc: c, tgt: 4'(rows.size()),
              a: a, src: s, imm12: i12, imm16: i16, flags: f, pc: p};
        rows.push_back(r);
    endtask

    // Control row; a valid instruction here must be ignored by the pipe
    task automatic add_ctl(logic st, logic fl, logic v);
        row_t r;
        r = '{valid: v, stall: st, flush: fl, opc: OPC_ADDur, cc: CC_RA, tgt: 4'hF,
              a: 24'h111111, src: 24'h222222, imm12: 12'hFFF, imm16: '0, flags: '0, pc: '0};
        rows.push_back(r);
    endtask

    task automatic build_table();
        int          amts[7];
        logic [3:0]  fsets[7];
        opcode_e     rops[12];
        logic [31:0] x;
        logic [31:0] y;
        amts  = '{0, 1, DW - 1, DW, DW + 1, 2 * DW, 100};
        fsets = '{4'b0000, 4'b0001, 4'b0010, 4'b0100, 4'b1000, 4'b1010, 4'b0101};
        rops  = '{OPC_ADDur, OPC_SUBur, OPC_ADDsr, OPC_SUBsr, OPC_CMPur, OPC_CMPsr,
                  OPC_ANDur, OPC_XORui, OPC_ADDui, OPC_SHLur, OPC_RORur, OPC_MCCur};
        add_row(OPC_ADDur, CC_RA, 24'hFFFFFF, 24'h000001, 0, 0, 0, 0);
        add_row(OPC_ADDur, CC_RA, 24'h000005, 24'h000007, 0, 0, 0, 0);
        add_row(OPC_SUBur, CC_RA, 24'h000003, 24'h000005, 0, 0, 0, 0);
        add_row(OPC_SUBur, CC_RA, 24'h000005, 24'h000005, 0, 0, 0, 0);
        add_row(OPC_ADDsr, CC_RA, 24'h7FFFFF, 24'h000001, 0, 0, 0, 0);
        add_row(OPC_ADDsr, CC_RA, 24'h800000, 24'h800000, 0, 0, 0, 0);
        add_row(OPC_SUBsr, CC_RA, 24'h800000, 24'h000001, 0, 0, 0, 0);
        add_row(OPC_SUBsr, CC_RA, 24'h000001, 24'h000002, 0, 0, 0, 0);
        add_row(OPC_CMPur, CC_RA, 24'h000010, 24'h000020, 0, 0, 0, 0);
        add_row(OPC_CMPur, CC_RA, 24'h123456, 24'h123456, 0, 0, 0, 0);
        add_row(OPC_CMPsr, CC_RA, 24'h7FFFFF, 24'h800000, 0, 0, 0, 0);
        add_row(OPC_TSTur, CC_RA, 24'h000000, 24'h000000, 0, 0, 0, 0);
        add_row(OPC_TSTur, CC_RA, 24'h000005, 24'h000000, 0, 0, 0, 0);
        add_row(OPC_ANDur, CC_RA, 24'hF0F0F0, 24'h0F0F0F, 0, 0, 0, 0);
        add_row(OPC_ORur,  CC_RA, 24'hF0F0F0, 24'h0F0F0F, 0, 0, 0, 0);
        add_row(OPC_XORur, CC_RA, 24'hA5A5A5, 24'hA5A5A5, 0, 0, 0, 0);
        add_row(OPC_NOTur, CC_RA, 24'hFFFFFF, 24'h000000, 0, 0, 0, 0);
        add_row(OPC_MOVur, CC_RA, 24'h000000, 24'h000000, 0, 0, 0, 0);
        foreach (amts[i]) begin
            add_row(OPC_SHLur, CC_RA, 24'h800001, DW'(amts[i]), 0, 0, 0, 0);
            add_row(OPC_SHRur, CC_RA, 24'h800001, DW'(amts[i]), 0, 0, 0, 0);
            add_row(OPC_ROLur, CC_RA, 24'hA00005, DW'(amts[i]), 0, 0, 0, 0);
            add_row(OPC_RORur, CC_RA, 24'hA00005, DW'(amts[i]), 0, 0, 0, 0);
        end
        add_row(OPC_LUIui, CC_RA, 0, 0, 12'hABC, 0, 0, 0);
        add_row(OPC_MOVui, CC_RA, 0, 0, 12'h123, 0, 0, 0);
        add_row(OPC_ADDui, CC_RA, 24'h000100, 0, 12'hF00, 0, 0, 0);
        add_row(OPC_SUBui, CC_RA, 24'h000100, 0, 12'h001, 0, 0, 0);
        add_row(OPC_ANDui, CC_RA, 24'hFFFFFF, 0, 12'h0F0, 0, 0, 0);
        add_row(OPC_ORui,  CC_RA, 24'h000001, 0, 12'h010, 0, 0, 0);
        add_row(OPC_XORui, CC_RA, 24'hABC123, 0, 12'h123, 0, 0, 0);
        add_row(OPC_MOVsi, CC_RA, 0, 0, 12'h800, 0, 0, 0);
        add_row(OPC_MOVsi, CC_RA, 0, 0, 12'h7FF, 0, 0, 0);
        add_ctl(1'b0, 1'b1, 1'b1);
        add_row(OPC_MOVui, CC_RA, 0, 0, 12'h456, 0, 0, 0);
        for (int c = 0; c < 11; c++) begin
            foreach (fsets[i]) begin
                add_row(OPC_MCCur, cc_e'(c), 24'h00AAAA, 24'h000000, 0, 0, fsets[i], 0);
                add_row(OPC_BCCso, cc_e'(c), 0, 0, 12'h804, 0, fsets[i], 48'h0000_0010_0000);
            end
        end
        add_row(OPC_BALso, CC_EQ, 0, 0, 0, 16'h8000, 4'b0000, 48'h0000_0001_0000);
        add_row(OPC_BALso, CC_NE, 0, 0, 0, 16'h1234, 4'b0001, 48'hFFFF_FFFF_FFF0);
        add_row(OPC_ADDur, CC_RA, 24'h000010, 24'h000020, 0, 0, 0, 0);
        add_row(OPC_SUBur, CC_RA, 24'h000010, 24'h000020, 0, 0, 0, 0);
        repeat (3) add_ctl(1'b1, 1'b0, 1'b1);
        add_row(OPC_ADDur, CC_RA, 24'h000001, 24'h000002, 0, 0, 0, 0);
        add_row(OPC_SUBur, CC_RA, 24'h000009, 24'h000002, 0, 0, 0, 0);
        add_ctl(1'b0, 1'b1, 1'b1);
        add_ctl(1'b0, 1'b0, 1'b0);
        lcg_state = 32'd48;
        repeat (40) begin
            x = lcg_next();
            y = lcg_next();
            add_row(rops[x[31:16] % 12], cc_e'(y[31:16] % 11), DW'(x[23:0] ^ y[31:8]),
                    (x[8] ? DW'(y[31:27]) : DW'(y[27:4])), y[15:4], 0, x[27:24], 0);
            if (y[2:0] == 3'd0) begin
                add_ctl(1'b1, 1'b0, 1'b1);
            end
        end
        repeat (3) add_ctl(1'b0, 1'b0, 1'b0);
    endtask

    task automatic drive(row_t r);
        in_valid = r.valid;
        stall    = r.stall;
        flush    = r.flush;
        opc      = r.opc;
        cc       = r.cc;
        tgt      = r.tgt;
        tgt_val  = r.a;
        src_val  = r.src;
        imm12    = r.imm12;
        imm16    = r.imm16;
        flags    = r.flags;
        pc       = r.pc;
    endtask

    // Two-slot pipeline model, stepped on each rising edge
    task automatic model_step(row_t r);
        if (!r.stall) begin
            if (r.flush) begin
                s1_v = 1'b0;
                s2_v = 1'b0;
                bank = '0;
            end else begin
                s2   = s1;
                s2_v = s1_v;
                s1_v = r.valid;
                if (r.valid) begin
                    s1 = expect_row(r, bank);
                end
                if (r.valid && r.opc == OPC_LUIui) begin
                    bank = r.imm12;
                end
            end
        end
    endtask

    task automatic check_outputs();
        compare("out_valid", 64'(out_valid), 64'(s2_v));
        if (s2_v) begin
            compare("gp_we", 64'(gp_we), 64'(s2.gp_we));
            compare("flags_we", 64'(flags_we), 64'(s2.fl_we));
            compare("branch_taken", 64'(branch_taken), 64'(s2.br));
            compare("gp_tgt", 64'(gp_tgt), 64'(s2.tgt));
            if (s2.gp_we) compare("result", 64'(result), 64'(s2.res));
            if (s2.fl_we) compare("flags_out", 64'(flags_out), 64'(s2.fl));
            if (s2.br) compare("branch_pc", 64'(branch_pc), 64'(s2.bpc));
        end else begin
            compare("idle write/branch", 64'({gp_we, flags_we, branch_taken}), 64'd0);
        end
    endtask

    initial begin
        drive('{valid: 1'b0, stall: 1'b0, flush: 1'b0, opc: OPC_MOVur, cc: CC_RA, default: '0});
        s1 = '0;
        s2 = '0;
        s1_v = 1'b0;
        s2_v = 1'b0;
        bank = '0;
        build_table();
        @(negedge iw_rst);
        check_outputs();
        foreach (rows[i]) begin
            drive(rows[i]);
            @(posedge iw_clk);
            model_step(rows[i]);
            @(negedge iw_clk);
            check_outputs();
        end
        $display(">>> PASS");
        $finish;
    end

    initial begin
        #1;
        repeat (rows.size() * 4 + 16) @(posedge iw_clk);
        $display("Watchdog expired before the stimulus table finished");
        $display(">>> FAIL");
        $fatal(1);
    end

endmodule

/* filelist.f */
ex_pkg.sv
ex_shift_unit.sv
ex_cond_eval.sv
ex_operand_stage.sv
ex_compute_stage.sv
ex_top.sv
tb_clock_gen.sv
tb_ex_top.sv

/* run_sim.sh */
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_ex_top -f filelist.f \
    -o sim_ex > build.log 2>&1 && ./obj_dir/sim_ex > sim.log 2>&1 || echo "run ended with error" >> sim.log
cat sim.log
grep -q ">>> FAIL" sim.log && { echo "RESULT: FAIL"; exit 1; }
grep -q ">>> PASS" sim.log && echo "RESULT: PASS" || { echo "RESULT: FAIL (see build.log)"; exit 1; }
